// File: design/pt_line_reader.sv
// Page table line reader
// Issues one memory line read per entry read, single outstanding
// Registers the line, then the selected word, then decodes the entry

`timescale 1ns/1ps

module pt_line_reader
    import vtp_addr_pkg::*, pt_walk_pkg::*;
#(
    parameter int LINE_WORDS = 8
)
(
    input  logic clk,
    input  logic reset,

    // Memory read request
    output logic mem_req_valid,
    input  logic mem_req_ready,
    output t_line_addr mem_req_addr,

    // Memory read response, one line per accepted request
    input  logic mem_rsp_valid,
    input  t_line mem_rsp_data,

    // Entry reads from the walker
    pt_read_if.reader rd
);

    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

    // Read outstanding from acceptance until the entry is returned
    logic busy;

    // Word position of the outstanding read
    logic [WORD_IDX_BITS-1:0] req_word;

    // Response pipeline
    t_line line_q;
    logic line_en_q;
    logic [PTE_BITS-1:0] word_q;
    logic word_en_q;

    // Line viewed as entries
    logic [LINE_WORDS-1:0][PTE_BITS-1:0] line_words;

    assign rd.rd_ready = !busy;

    // ======================================================================
    // Request path
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            if (rd.rd_valid && !busy)
            begin
                busy <= 1'b1;
                mem_req_valid <= 1'b1;
            end
            else
            begin
                // Drop valid once memory takes the request
                if (mem_req_ready)
                begin
                    mem_req_valid <= 1'b0;
                end

                // Free again when the entry goes out
                if (word_en_q)
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Address and word position, held while the read is outstanding
    always_ff @(posedge clk)
    begin
        if (rd.rd_valid && !busy)
        begin
            mem_req_addr <= t_line_addr'({rd.rd_page, rd.rd_line});
            req_word <= rd.rd_word;
        end
    end

    // ======================================================================
    // Response path
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_en_q <= 1'b0;
            word_en_q <= 1'b0;
        end
        else
        begin
            line_en_q <= mem_rsp_valid;
            word_en_q <= line_en_q;
        end
    end

    assign line_words = line_q[LINE_WORDS*PTE_BITS-1:0];

    always_ff @(posedge clk)
    begin
        // Stage 1: capture the whole line
        if (mem_rsp_valid)
        begin
            line_q <= mem_rsp_data;
        end

        // Stage 2: keep only the requested entry
        if (line_en_q)
        begin
            word_q <= line_words[req_word];
        end
    end

    // Entry decode from fixed bit positions
    assign rd.ent_valid = word_en_q;
    assign rd.ent_status.error = word_q[PTE_ERROR_BIT];
    assign rd.ent_status.terminal = word_q[PTE_TERMINAL_BIT];
    assign rd.ent_page = word_q[PTE_PAGE_LSB +: PA_PAGE_BITS];

endmodule

// File: design/pt_read_if.sv
// Entry read channel between the walk FSM and the line reader
// Read request with valid/ready, decoded entry returned as a pulse
// Splits the entry index into line and word parts for the reader

`timescale 1ns/1ps

interface pt_read_if
    import vtp_addr_pkg::*, pt_walk_pkg::*;
#(
    parameter int LINE_WORDS = 8
);

    // Index split for the configured line size
    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);
    localparam int LINE_IDX_BITS = PT_IDX_BITS - WORD_IDX_BITS;

    // Read request, held by the walker while rd_valid is high
    logic rd_valid;
    t_pa_page rd_page;
    t_pt_idx rd_idx;
    logic rd_ready;

    // Decoded entry, single cycle, no back-pressure
    logic ent_valid;
    t_pte_status ent_status;
    t_pa_page ent_page;

    // Line within the table page and word within that line
    logic [LINE_IDX_BITS-1:0] rd_line;
    logic [WORD_IDX_BITS-1:0] rd_word;

    assign rd_line = rd_idx[PT_IDX_BITS-1 -: LINE_IDX_BITS];
    assign rd_word = rd_idx[WORD_IDX_BITS-1:0];

    modport walker (
        output rd_valid, rd_page, rd_idx,
        input  rd_ready, ent_valid, ent_status, ent_page
    );

    modport reader (
        input  rd_valid, rd_page, rd_line, rd_word,
        output rd_ready, ent_valid, ent_status, ent_page
    );

endinterface

// File: design/pt_walk_fsm.sv
// Page table walk FSM
// Captures one translation request, walks up to four table levels
// Forms the 4KB, 2MB or not-present result and holds it until accepted

`timescale 1ns/1ps

module pt_walk_fsm
    import vtp_addr_pkg::*, pt_walk_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Translation request
    input  logic req_valid,
    output logic req_ready,
    input  t_va_page req_va,
    input  t_req_tag req_tag,

    // Root table page, stable while idle
    input  t_pa_page pt_root,

    // Translation response
    output logic rsp_valid,
    input  logic rsp_ready,
    output t_va_page rsp_va,
    output t_pa_page rsp_pa,
    output t_req_tag rsp_tag,
    output logic rsp_big_page,
    output logic rsp_not_present,

    // Entry reads
    pt_read_if.walker rd
);

    // Depths where a terminal entry gives a valid page
    localparam t_pt_depth DEPTH_4KB = t_pt_depth'(PT_MAX_DEPTH - 1);
    localparam t_pt_depth DEPTH_2MB = t_pt_depth'(PT_MAX_DEPTH - 2);

    t_walk_state state;

    // Request being translated
    t_va_page walk_va;
    t_req_tag walk_tag;

    // Page of the table level being read
    t_pa_page cur_page;

    // Remaining indices, next one in the top element
    t_pt_idx_vec idx_vec;
    t_pt_depth depth;

    // Entry returned for the current level
    t_pte_status ent_status_q;
    t_pa_page ent_page_q;

    // One walk at a time
    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND);

    // Read the entry for the current level
    assign rd.rd_valid = (state == READ_REQ);
    assign rd.rd_page = cur_page;
    assign rd.rd_idx = idx_vec[PT_MAX_DEPTH-1];

    // ======================================================================
    // Walk control
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req_valid)
                    begin
                        state <= READ_REQ;
                    end
                end

                READ_REQ:
                begin
                    // Wait for the reader to take the read
                    if (rd.rd_ready)
                    begin
                        state <= READ_WAIT;
                    end
                end

                READ_WAIT:
                begin
                    if (rd.ent_valid)
                    begin
                        state <= CHECK;
                    end
                end

                CHECK:
                begin
                    // Descend only through a clean non-terminal entry above the last level
                    if (!ent_status_q.error && !ent_status_q.terminal && (depth != DEPTH_4KB))
                    begin
                        state <= READ_REQ;
                    end
                    else
                    begin
                        state <= RESPOND;
                    end
                end

                RESPOND:
                begin
                    if (rsp_ready)
                    begin
                        state <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Walk datapath
    // ======================================================================

    always_ff @(posedge clk)
    begin
        // New request, start at the root with the full index vector
        if ((state == IDLE) && req_valid)
        begin
            walk_va <= req_va;
            walk_tag <= req_tag;
            cur_page <= pt_root;
            idx_vec <= t_pt_idx_vec'(req_va);
            depth <= '0;
        end

        // Keep the entry, the pulse lasts one cycle
        if ((state == READ_WAIT) && rd.ent_valid)
        begin
            ent_status_q <= rd.ent_status;
            ent_page_q <= rd.ent_page;
        end

        // Next level: entry page becomes the table, drop the used index
        if ((state == CHECK) && !ent_status_q.error && !ent_status_q.terminal &&
            (depth != DEPTH_4KB))
        begin
            cur_page <= ent_page_q;
            idx_vec <= {idx_vec[PT_MAX_DEPTH-2:0], t_pt_idx'(0)};
            depth <= depth + t_pt_depth'(1);
        end
    end

    // ======================================================================
    // Result formation
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (state == CHECK)
        begin
            rsp_va <= walk_va;
            rsp_tag <= walk_tag;
            rsp_big_page <= 1'b0;

            if (ent_status_q.error)
            begin
                // Missing or invalid entry
                rsp_pa <= t_pa_page'(0);
                rsp_not_present <= 1'b1;
            end
            else if (ent_status_q.terminal && (depth == DEPTH_4KB))
            begin
                rsp_pa <= ent_page_q;
                rsp_not_present <= 1'b0;
            end
            else if (ent_status_q.terminal && (depth == DEPTH_2MB))
            begin
                rsp_pa <= ent_page_q;
                rsp_big_page <= 1'b1;
                rsp_not_present <= 1'b0;
            end
            else
            begin
                // Terminal too high in the table, or no terminal at the last level
                rsp_pa <= t_pa_page'(0);
                rsp_not_present <= 1'b1;
            end
        end
    end

endmodule

// File: design/pt_walk_pkg.sv
// Page table format for a four-level hierarchical table
// Index, depth and entry status types
// Entry bit positions and the walk state encoding

package pt_walk_pkg;

    // ======================================================================
    // Table geometry
    // ======================================================================

    // Each table page holds 512 entries of 64 bits
    localparam int PT_IDX_BITS = 9;

    // Levels of indirection
    localparam int PT_MAX_DEPTH = 4;

    // Width of one table entry
    localparam int PTE_BITS = 64;

    typedef logic [PT_IDX_BITS-1:0] t_pt_idx;

    // All level indices, highest element holds the root level index
    typedef t_pt_idx [PT_MAX_DEPTH-1:0] t_pt_idx_vec;

    // Current level during a walk, 0 is the root
    typedef logic [$clog2(PT_MAX_DEPTH)-1:0] t_pt_depth;

    // Flags decoded from an entry
    typedef struct packed
    {
        // No valid translation, empty entries are all ones
        logic error;
        // Entry points to the translated page, not another table
        logic terminal;
    } t_pte_status;

    // ======================================================================
    // Entry bit positions
    // ======================================================================

    localparam int PTE_TERMINAL_BIT = 0;
    localparam int PTE_ERROR_BIT = 3;

    // Page number occupies PA_PAGE_BITS starting here
    localparam int PTE_PAGE_LSB = 12;

    // Walk FSM states
    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        READ_WAIT,
        CHECK,
        RESPOND
    } t_walk_state;

endpackage

// File: design/pt_walk_top.sv
// Page table walker top level
// Walk FSM and line reader joined by the entry read interface
// Translation, memory and table root signals as plain ports

`timescale 1ns/1ps

module pt_walk_top
    import vtp_addr_pkg::*;
#(
    // 64-bit entries per memory line
    parameter int LINE_WORDS = 8
)
(
    input  logic clk,
    input  logic reset,

    // Translation request
    input  logic req_valid,
    output logic req_ready,
    input  t_va_page req_va,
    input  t_req_tag req_tag,

    // Translation response
    output logic rsp_valid,
    input  logic rsp_ready,
    output t_va_page rsp_va,
    output t_pa_page rsp_pa,
    output t_req_tag rsp_tag,
    output logic rsp_big_page,
    output logic rsp_not_present,

    // Memory read request
    output logic mem_req_valid,
    input  logic mem_req_ready,
    output t_line_addr mem_req_addr,

    // Memory read response
    input  logic mem_rsp_valid,
    input  t_line mem_rsp_data,

    // Root of the page table
    input  t_pa_page pt_root
);

    // Entry reads between FSM and reader
    pt_read_if #(
        .LINE_WORDS(LINE_WORDS)
    ) rd_bus ();

    pt_walk_fsm u_walk_fsm (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_va          (req_va),
        .req_tag         (req_tag),
        .pt_root         (pt_root),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .rsp_va          (rsp_va),
        .rsp_pa          (rsp_pa),
        .rsp_tag         (rsp_tag),
        .rsp_big_page    (rsp_big_page),
        .rsp_not_present (rsp_not_present),
        .rd              (rd_bus.walker)
    );

    pt_line_reader #(
        .LINE_WORDS(LINE_WORDS)
    ) u_line_reader (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .rd            (rd_bus.reader)
    );

endmodule

// File: design/vtp_addr_pkg.sv
// Address field widths for virtual to physical translation
// Types for virtual pages, physical pages, memory lines and line addresses
// Request tag type carried through a walk

package vtp_addr_pkg;

    // ======================================================================
    // Field widths
    // ======================================================================

    // Virtual 4KB page index, a 48-bit VA without its 12 offset bits
    localparam int VA_PAGE_BITS = 36;

    // Physical 4KB page index
    localparam int PA_PAGE_BITS = 40;

    // Line address bits inside one 4KB page (64-byte lines)
    localparam int PAGE_OFFSET_LINES = 6;

    // One memory line
    localparam int LINE_BITS = 512;

    // Tag carried with a translation request
    localparam int REQ_TAG_BITS = 8;

    // Line address is the page followed by the line within the page
    localparam int LINE_ADDR_BITS = PA_PAGE_BITS + PAGE_OFFSET_LINES;

    // ======================================================================
    // Address types
    // ======================================================================

    typedef logic [VA_PAGE_BITS-1:0] t_va_page;

    typedef logic [PA_PAGE_BITS-1:0] t_pa_page;

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;

    typedef logic [LINE_BITS-1:0] t_line;

    typedef logic [REQ_TAG_BITS-1:0] t_req_tag;

endpackage

// File: test/pt_walk_sva.sv
// Protocol assertions for the page table walker top level
// Memory request and response holding, one walk at a time, single outstanding read
// Bound to every pt_walk_top instance

`timescale 1ns/1ps

module pt_walk_sva
    import vtp_addr_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic req_ready,
    input logic rsp_valid,
    input logic rsp_ready,
    input t_va_page rsp_va,
    input t_pa_page rsp_pa,
    input t_req_tag rsp_tag,
    input logic rsp_big_page,
    input logic rsp_not_present,
    input logic mem_req_valid,
    input logic mem_req_ready,
    input t_line_addr mem_req_addr,
    input logic mem_rsp_valid
);

    // Set from an accepted memory read until its line returns
    logic rd_outstanding;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_outstanding <= 1'b0;
        end
        else if (mem_req_valid && mem_req_ready)
        begin
            rd_outstanding <= 1'b1;
        end
        else if (mem_rsp_valid)
        begin
            rd_outstanding <= 1'b0;
        end
    end

    // Memory request held until taken
    a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("memory request dropped or changed before mem_req_ready");

    // Response held until taken
    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_va) && $stable(rsp_pa) &&
            $stable(rsp_tag) && $stable(rsp_big_page) && $stable(rsp_not_present))
        else $error("response dropped or changed before rsp_ready");

    a_no_req_while_rsp: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

    a_single_read: assert property (@(posedge clk) disable iff (reset)
        rd_outstanding |-> !mem_req_valid)
        else $error("second memory request while a read is outstanding");

endmodule

bind pt_walk_top pt_walk_sva u_pt_walk_sva (.*);

// File: test/pt_walk_tb.sv
// Testbench for the page table walker
// Clock, reset, table memory model with random delay and back-pressure
// Reference walk, response comparison, watchdog and final report

`timescale 1ns/1ps

module pt_walk_tb
    import vtp_addr_pkg::*, pt_walk_pkg::*;
();

    localparam int LINE_WORDS = 8;

    // How map_path ends a walk
    localparam int KIND_LEAF = 0;
    localparam int KIND_ERROR = 1;
    localparam int KIND_MISSING = 2;
    localparam int KIND_TABLE = 3;

    localparam int RAND_REQS = 200;

    typedef struct packed
    {
        t_va_page va;
        t_req_tag tag;
        t_pa_page pa;
        logic big;
        logic np;
    } t_expect;

    logic clk;
    logic reset;
    logic req_valid;
    logic req_ready;
    t_va_page req_va;
    t_req_tag req_tag;
    logic rsp_valid;
    logic rsp_ready;
    t_va_page rsp_va;
    t_pa_page rsp_pa;
    t_req_tag rsp_tag;
    logic rsp_big_page;
    logic rsp_not_present;
    logic mem_req_valid;
    logic mem_req_ready;
    t_line_addr mem_req_addr;
    logic mem_rsp_valid;
    t_line mem_rsp_data;
    t_pa_page pt_root;

    // Table memory, keyed by {page, entry index}
    logic [63:0] pte_mem [logic [48:0]];
    t_pa_page next_page = 40'h100;

    t_expect exp_q [$];
    t_expect got_exp;
    integer seed = 32'h375d;
    logic stall;
    int issued;
    int checked;
    int errors;
    int n_tests;
    int test_err0;
    int test_chk0;
    string test_name;
    int watchdog_cycles;

    // Memory model state
    logic take;
    t_line_addr take_addr;
    logic pending;
    t_line_addr pend_addr;
    int delay;

    t_va_page rand_va [RAND_REQS];

    pt_walk_top #(
        .LINE_WORDS(LINE_WORDS)
    ) u_pt_walk_top (.*);

    always #5 clk = ~clk;

    // ======================================================================
    // Table helpers and reference walk
    // ======================================================================

    // Entry formats: page at bit 12, terminal at bit 0, error at bit 3
    function automatic logic [63:0] table_entry(input t_pa_page page);
        return {12'h000, page, 12'h000};
    endfunction

    function automatic logic [63:0] leaf_entry(input t_pa_page page);
        return {12'h000, page, 12'h001};
    endfunction

    // Unmapped entries read as all ones
    function automatic logic [63:0] read_entry(input t_pa_page page, input logic [8:0] idx);
        if (pte_mem.exists({page, idx}))
        begin
            return pte_mem[{page, idx}];
        end
        return '1;
    endfunction

    function automatic t_line read_line(input t_line_addr addr);
        t_line line;
        int w;
        line = '0;
        for (w = 0; w < LINE_WORDS; w++)
        begin
            line[w*64 +: 64] = read_entry(addr[45:6], {addr[5:0], 3'(w)});
        end
        return line;
    endfunction

    // Expected result of walking va from root
    function automatic void ref_walk(input t_pa_page root, input t_va_page va,
                                     output t_pa_page pa, output logic big, output logic np);
        t_pa_page page;
        logic [63:0] e;
        logic done;
        int d;
        page = root;
        pa = '0;
        big = 1'b0;
        np = 1'b1;
        done = 1'b0;
        for (d = 0; d < 4; d++)
        begin
            if (!done)
            begin
                e = read_entry(page, va[35 - 9*d -: 9]);
                if (e[3])
                begin
                    done = 1'b1;
                end
                else if (e[0])
                begin
                    done = 1'b1;
                    // Leaf counts only at depth 3 (4KB) or depth 2 (2MB)
                    if (d >= 2)
                    begin
                        pa = e[51:12];
                        big = (d == 2);
                        np = 1'b0;
                    end
                end
                else if (d == 3)
                begin
                    done = 1'b1;
                end
                else
                begin
                    page = e[51:12];
                end
            end
        end
    endfunction

    // Build table levels above depth, reusing existing table entries
    task automatic map_path(input t_pa_page root, input t_va_page va, input int depth,
                            input int kind, input t_pa_page leaf, output t_pa_page last_page);
        t_pa_page page;
        logic [48:0] key;
        logic stop;
        int d;
        page = root;
        stop = 1'b0;
        for (d = 0; d < depth; d++)
        begin
            if (!stop)
            begin
                key = {page, va[35 - 9*d -: 9]};
                if (!pte_mem.exists(key))
                begin
                    pte_mem[key] = table_entry(next_page);
                    next_page++;
                end
                if (pte_mem[key][3] || pte_mem[key][0])
                begin
                    stop = 1'b1;
                end
                else
                begin
                    page = pte_mem[key][51:12];
                end
            end
        end
        last_page = page;
        key = {page, va[35 - 9*depth -: 9]};
        if (!stop && !pte_mem.exists(key))
        begin
            case (kind)
                KIND_LEAF:  pte_mem[key] = leaf_entry(leaf);
                // Error must win over a terminal flag
                KIND_ERROR: pte_mem[key] = leaf_entry(leaf) | 64'h8;
                KIND_TABLE:
                begin
                    pte_mem[key] = table_entry(next_page);
                    next_page++;
                end
                default: ;
            endcase
        end
    endtask

    // ======================================================================
    // Stimulus and checking
    // ======================================================================

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send_request(input t_va_page va, input t_req_tag tag);
        t_expect e;
        e.va = va;
        e.tag = tag;
        ref_walk(pt_root, va, e.pa, e.big, e.np);
        exp_q.push_back(e);
        issued++;
        req_valid = 1'b1;
        req_va = va;
        req_tag = tag;
        @(posedge clk);
        while (!req_ready)
        begin
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
        test_chk0 = checked;
    endtask

    // Wait for all responses, then report the test
    task automatic finish_test();
        wait (exp_q.size() == 0);
        @(posedge clk);
        #1;
        n_tests++;
        $display("[%0t] test %s: %0d responses, %0d errors", $time, test_name,
                 checked - test_chk0, errors - test_err0);
    endtask

    task automatic compare_value(input string name, input logic [39:0] got,
                                 input logic [39:0] want);
        assert (got === want)
        else
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset && rsp_valid && rsp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("ERROR at %0t: response with no request outstanding", $time);
                errors++;
            end
            else
            begin
                got_exp = exp_q.pop_front();
                compare_value("rsp_va", rsp_va, got_exp.va);
                compare_value("rsp_tag", rsp_tag, got_exp.tag);
                compare_value("rsp_pa", rsp_pa, got_exp.pa);
                compare_value("rsp_big_page", rsp_big_page, got_exp.big);
                compare_value("rsp_not_present", rsp_not_present, got_exp.np);
                checked++;
            end
        end
    end

    // Memory model and random back-pressure, driven 1 ns after the edge
    always @(posedge clk)
    begin
        take = mem_req_valid && mem_req_ready;
        take_addr = mem_req_addr;
        #1;
        mem_rsp_valid = 1'b0;
        if (reset)
        begin
            pending = 1'b0;
        end
        else
        begin
            if (pending)
            begin
                delay--;
                if (delay == 0)
                begin
                    mem_rsp_data = read_line(pend_addr);
                    mem_rsp_valid = 1'b1;
                    pending = 1'b0;
                end
            end
            if (take)
            begin
                pending = 1'b1;
                pend_addr = take_addr;
                delay = 1 + ($unsigned($random(seed)) % 6);
            end
        end
        mem_req_ready = stall ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
        rsp_ready = stall ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
    end

    // Watchdog, limit grows with each request issued
    initial
    begin
        watchdog_cycles = 0;
        while (watchdog_cycles <= 200 * issued + 1000)
        begin
            @(posedge clk);
            watchdog_cycles++;
        end
        $display("ERROR at %0t: timeout, %0d responses still missing", $time, exp_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin : main
        t_pa_page tbl;
        t_va_page good_va;
        t_va_page va;
        logic [31:0] r;
        int kind;
        int i;

        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_va = '0;
        req_tag = '0;
        rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        stall = 1'b0;
        pt_root = 40'h10;
        issued = 0;
        checked = 0;
        errors = 0;
        n_tests = 0;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("walk_4kb");
        good_va = {9'd5, 9'd17, 9'd300, 9'd511};
        map_path(pt_root, good_va, 3, KIND_LEAF, 40'hab_cdef_0123, tbl);
        send_request(good_va, 8'h11);
        finish_test();

        start_test("walk_2mb");
        va = {9'd6, 9'd1, 9'd2, 9'd3};
        map_path(pt_root, va, 2, KIND_LEAF, 40'h12_3456_0200, tbl);
        send_request(va, 8'h22);
        finish_test();

        // Each failed walk is followed by a good one
        start_test("failed_walks");
        for (i = 0; i < 4; i++)
        begin
            va = {9'(100 + i), 9'd4, 9'd5, 9'd6};
            map_path(pt_root, va, i, KIND_MISSING, '0, tbl);
            send_request(va, 8'(8'h30 + i));
            send_request(good_va, 8'h3f);
        end
        // Error on a leaf at the last level, where the terminal flag alone would map
        va = {9'd104, 9'd7, 9'd8, 9'd9};
        map_path(pt_root, va, 3, KIND_ERROR, 40'h55, tbl);
        send_request(va, 8'h34);
        send_request(good_va, 8'h3f);
        va = {9'd105, 9'd7, 9'd8, 9'd9};
        map_path(pt_root, va, 3, KIND_TABLE, '0, tbl);
        send_request(va, 8'h35);
        send_request(good_va, 8'h3f);
        va = {9'd106, 9'd7, 9'd8, 9'd9};
        map_path(pt_root, va, 0, KIND_LEAF, 40'h66, tbl);
        send_request(va, 8'h36);
        send_request(good_va, 8'h3f);
        finish_test();

        // Every entry of one leaf table holds its own page
        start_test("word_select");
        va = {9'd7, 9'd8, 9'd9, 9'd0};
        map_path(pt_root, va, 3, KIND_LEAF, '0, tbl);
        for (i = 0; i < 512; i++)
        begin
            pte_mem[{tbl, 9'(i)}] = leaf_entry(40'h7_0000 + i);
        end
        for (i = 0; i < 16; i++)
        begin
            send_request({9'd7, 9'd8, 9'd9, 9'((i * 37 + 3) % 512)}, 8'(8'h40 + i));
        end
        finish_test();

        // Random table on a fresh root, upper indices narrowed for sharing
        start_test("random_backpressure");
        pt_root = next_page;
        next_page++;
        for (i = 0; i < RAND_REQS; i++)
        begin
            r = $random(seed);
            rand_va[i] = {7'd0, r[1:0], 7'd0, r[3:2], r[12:4], r[21:13]};
            kind = $unsigned($random(seed)) % 10;
            if (kind < 6)
            begin
                map_path(pt_root, rand_va[i], 3, KIND_LEAF, t_pa_page'($random(seed)), tbl);
            end
            else if (kind == 6)
            begin
                map_path(pt_root, rand_va[i], 2, KIND_LEAF, t_pa_page'($random(seed)), tbl);
            end
            else if (kind == 7)
            begin
                map_path(pt_root, rand_va[i], 2 + (r[22] ? 1 : 0), KIND_ERROR, 40'h9, tbl);
            end
            else if (kind == 8)
            begin
                map_path(pt_root, rand_va[i], 2 + (r[23] ? 1 : 0), KIND_MISSING, '0, tbl);
            end
            else
            begin
                map_path(pt_root, rand_va[i], 3, KIND_TABLE, '0, tbl);
            end
        end
        stall = 1'b1;
        for (i = 0; i < RAND_REQS; i++)
        begin
            send_request(rand_va[i], 8'(i));
        end
        finish_test();
        stall = 1'b0;

        $display("tests: %0d, responses checked: %0d, errors: %0d", n_tests, checked, errors);
        if (errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/vtp_addr_pkg.sv
design/pt_walk_pkg.sv
design/pt_read_if.sv
design/pt_walk_fsm.sv
design/pt_line_reader.sv
design/pt_walk_top.sv
test/pt_walk_sva.sv
test/pt_walk_tb.sv
